// ==== design/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

    // ######################################################################
    // Sizes
    // ######################################################################
    localparam int imem_addr_w = 10;                  // Byte address, 1 KiB.
    localparam int imem_lines  = (1 << imem_addr_w) / 8;
    localparam int fbuf_depth  = 16;                  // Words.
    localparam int fbuf_cnt_w  = 5;

    // ######################################################################
    // Types
    // ######################################################################
    typedef logic [31:0] insn_t;

    typedef struct packed {
        insn_t second;                                // Upper address word.
        insn_t first;                                 // Lower address word.
    } fetch_pair_t;

    typedef enum logic {
        req_host  = 1'b0,
        req_fetch = 1'b1
    } req_id_e;

    typedef struct packed {
        logic                   valid;
        logic                   write;
        logic [imem_addr_w-1:0] addr;                 // 8-byte aligned.
        logic [63:0]            wdata;
        logic [7:0]             strb;
    } mem_req_t;

    typedef struct packed {
        logic        valid;
        req_id_e     tag;
        logic [63:0] rdata;
    } mem_rsp_t;

    typedef struct packed {
        logic [imem_addr_w-1:0] pc;
        insn_t                  insn;
    } fetch_word_t;

    typedef struct packed {
        logic                   valid;
        logic [imem_addr_w-1:0] pc;
        insn_t                  insn;
    } slot_t;

endpackage

`default_nettype wire

// ==== design/imem_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module imem_ram import fetch_pkg::*; (
    input  wire logic        clk,
    input  wire mem_req_t    req,
    output logic [63:0]      rdata
);

    logic [63:0]            mem [imem_lines];
    logic [imem_addr_w-4:0] idx;

    assign idx = req.addr[imem_addr_w-1:3];          // Line index.

    always_ff @(posedge clk) begin
        if (req.valid) begin
            if (req.write) begin
                for (int b = 0; b < 8; b++) begin
                    if (req.strb[b]) begin
                        mem[idx][8*b +: 8] <= req.wdata[8*b +: 8];
                    end
                end
            end else begin
                rdata <= mem[idx];                    // One cycle latency.
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/imem_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module imem_arbiter import fetch_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rstn,
    input  wire mem_req_t    host_req,
    input  wire mem_req_t    fetch_req,
    output logic             host_gnt,
    output logic             fetch_gnt,
    output mem_req_t         mem_req,
    input  wire logic [63:0] mem_rdata,
    output mem_rsp_t         rsp
);

    logic    prio_fetch;                              // Fetch wins a tie.
    logic    rd_pend;
    req_id_e rd_tag;

    // ######################################################################
    // Grant
    // ######################################################################
    assign host_gnt  = host_req.valid && (!fetch_req.valid || !prio_fetch);
    assign fetch_gnt = fetch_req.valid && !host_gnt;

    assign mem_req = host_gnt  ? host_req :
                     fetch_gnt ? fetch_req : '0;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            prio_fetch <= 1'b0;
        end else if (host_gnt || fetch_gnt) begin
            prio_fetch <= host_gnt;                   // Loser goes first next.
        end
    end

    // ######################################################################
    // Response routing
    // ######################################################################
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rd_pend <= 1'b0;
            rd_tag  <= req_host;
        end else begin
            rd_pend <= mem_req.valid && !mem_req.write;
            rd_tag  <= fetch_gnt ? req_fetch : req_host;
        end
    end

    always_comb begin
        rsp.valid = rd_pend;
        rsp.tag   = rd_tag;
        rsp.rdata = mem_rdata;
    end

endmodule

`default_nettype wire

// ==== design/host_axil_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module host_axil_port import fetch_pkg::*; (
    input  wire logic                   clk,
    input  wire logic                   rstn,
    input  wire logic                   axil_awvalid,
    output logic                        axil_awready,
    input  wire logic [imem_addr_w-1:0] axil_awaddr,
    input  wire logic                   axil_wvalid,
    output logic                        axil_wready,
    input  wire logic [31:0]            axil_wdata,
    input  wire logic [3:0]             axil_wstrb,
    output logic                        axil_bvalid,
    input  wire logic                   axil_bready,
    output logic [1:0]                  axil_bresp,
    input  wire logic                   axil_arvalid,
    output logic                        axil_arready,
    input  wire logic [imem_addr_w-1:0] axil_araddr,
    output logic                        axil_rvalid,
    input  wire logic                   axil_rready,
    output logic [31:0]                 axil_rdata,
    output logic [1:0]                  axil_rresp,
    output mem_req_t                    req,
    input  wire logic                   gnt,
    input  wire mem_rsp_t               rsp
);

    typedef enum logic [2:0] {
        st_idle,
        st_req,
        st_wait,
        st_resp_b,
        st_resp_r
    } state_e;

    state_e                 state;
    logic                   is_write;
    logic [imem_addr_w-1:0] addr_q;
    logic [31:0]            wdata_q;
    logic [3:0]             strb_q;
    logic                   wr_go;
    logic                   rd_go;

    // AW and W only ever transfer together; writes win over reads.
    assign axil_awready = (state == st_idle) && !(axil_awvalid && !axil_wvalid);
    assign axil_wready  = (state == st_idle) && !(axil_wvalid && !axil_awvalid);
    assign axil_arready = (state == st_idle) && !(axil_awvalid && axil_wvalid);
    assign wr_go        = axil_awvalid && axil_awready && axil_wvalid && axil_wready;
    assign rd_go        = axil_arvalid && axil_arready;

    assign axil_bvalid = (state == st_resp_b);
    assign axil_rvalid = (state == st_resp_r);
    assign axil_bresp  = 2'b00;                       // OKAY.
    assign axil_rresp  = 2'b00;

    always_comb begin
        req.valid = (state == st_req);
        req.write = is_write;
        req.addr  = {addr_q[imem_addr_w-1:3], 3'b000};
        req.wdata = {wdata_q, wdata_q};
        req.strb  = addr_q[2] ? {strb_q, 4'h0} : {4'h0, strb_q};
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state    <= st_idle;
            is_write <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (wr_go || rd_go) begin
                        state    <= st_req;
                        is_write <= wr_go;
                    end
                end
                st_req:    if (gnt) state <= is_write ? st_resp_b : st_wait;
                st_wait:   if (rsp.valid && rsp.tag == req_host) state <= st_resp_r;
                st_resp_b: if (axil_bready) state <= st_idle;
                st_resp_r: if (axil_rready) state <= st_idle;
                default:   state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_go) begin
            addr_q  <= axil_awaddr;
            wdata_q <= axil_wdata;
            strb_q  <= axil_wstrb;
        end else if (rd_go) begin
            addr_q <= axil_araddr;
        end
        if (state == st_wait && rsp.valid && rsp.tag == req_host) begin
            axil_rdata <= addr_q[2] ? rsp.rdata[63:32] : rsp.rdata[31:0];
        end
    end

endmodule

`default_nettype wire

// ==== design/fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_unit import fetch_pkg::*; (
    input  wire logic                   clk,
    input  wire logic                   rstn,
    input  wire logic                   redirect_valid,
    input  wire logic [imem_addr_w-1:0] redirect_pc,
    output mem_req_t                    req,
    input  wire logic                   gnt,
    input  wire mem_rsp_t               rsp,
    input  wire logic [fbuf_cnt_w-1:0]  fill,
    output logic                        enq_valid,
    output logic [imem_addr_w-1:0]      enq_pc,
    output fetch_pair_t                 enq_pair,
    output logic                        enq_skip_first
);

    logic                   active;                   // Set by first redirect.
    logic [imem_addr_w-1:0] pc;                       // Next line to request.
    logic [imem_addr_w-1:0] rsp_pc;                   // Line of next good response.
    logic                   skip_first;
    logic                   epoch;
    logic [1:0]             fl_ep;                    // Epoch per read in flight.
    logic [1:0]             inflight;
    logic [fbuf_cnt_w:0]    need;
    logic                   push;
    logic                   pop;
    logic                   push_idx;
    logic                   stale;

    // ######################################################################
    // Request issue
    // ######################################################################
    assign need = {1'b0, fill} + {3'b000, inflight, 1'b0} + (fbuf_cnt_w+1)'(2);

    always_comb begin
        req.valid = active && !redirect_valid && (need <= fbuf_depth) && (inflight != 2'd2);
        req.write = 1'b0;
        req.addr  = pc;
        req.wdata = '0;
        req.strb  = '0;
    end

    assign push     = req.valid && gnt;
    assign pop      = rsp.valid && (rsp.tag == req_fetch);
    assign push_idx = inflight[0] && !pop;

    // ######################################################################
    // Response and enqueue
    // ######################################################################
    assign stale          = redirect_valid || (fl_ep[0] != epoch);
    assign enq_valid      = pop && !stale;
    assign enq_pc         = rsp_pc;
    assign enq_pair       = rsp.rdata;
    assign enq_skip_first = skip_first;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            active     <= 1'b0;
            pc         <= '0;
            rsp_pc     <= '0;
            skip_first <= 1'b0;
            epoch      <= 1'b0;
            fl_ep      <= '0;
            inflight   <= '0;
        end else begin
            inflight <= inflight + {1'b0, push} - {1'b0, pop};
            if (pop) fl_ep[0] <= fl_ep[1];
            if (push) fl_ep[push_idx] <= epoch;       // After the shift.
            if (redirect_valid) begin
                active     <= 1'b1;
                epoch      <= ~epoch;
                pc         <= {redirect_pc[imem_addr_w-1:3], 3'b000};
                rsp_pc     <= {redirect_pc[imem_addr_w-1:3], 3'b000};
                skip_first <= redirect_pc[2];
            end else begin
                if (push) pc <= pc + imem_addr_w'(8);
                if (enq_valid) begin
                    rsp_pc     <= rsp_pc + imem_addr_w'(8);
                    skip_first <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/fetch_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_buffer import fetch_pkg::*; (
    input  wire logic                   clk,
    input  wire logic                   rstn,
    input  wire logic                   flush,
    input  wire logic                   enq_valid,
    input  wire logic [imem_addr_w-1:0] enq_pc,
    input  wire fetch_pair_t            enq_pair,
    input  wire logic                   enq_skip_first,
    input  wire logic                   take0,
    input  wire logic                   take1,
    output slot_t                       slot0,
    output slot_t                       slot1,
    output logic [fbuf_cnt_w-1:0]       fill
);

    fetch_word_t           q [fbuf_depth];            // Entry 0 is the head.
    logic [fbuf_cnt_w-1:0] cnt;
    logic [fbuf_cnt_w-1:0] n_deq;
    logic [fbuf_cnt_w-1:0] n_enq;
    logic [fbuf_cnt_w-1:0] base;                      // First free entry after dequeue.
    fetch_word_t           w0;
    fetch_word_t           w1;

    // ######################################################################
    // Dequeue and enqueue amounts
    // ######################################################################
    always_comb begin
        n_deq = '0;
        if (take0 && cnt != '0) begin
            n_deq = (take1 && cnt > fbuf_cnt_w'(1)) ? fbuf_cnt_w'(2) : fbuf_cnt_w'(1);
        end
        n_enq = '0;
        if (enq_valid) begin
            n_enq = enq_skip_first ? fbuf_cnt_w'(1) : fbuf_cnt_w'(2);
        end
        base = cnt - n_deq;
    end

    // Odd redirect drops the lower word of the line.
    always_comb begin
        w1.pc   = enq_pc + imem_addr_w'(4);
        w1.insn = enq_pair.second;
        w0      = w1;
        if (!enq_skip_first) begin
            w0.pc   = enq_pc;
            w0.insn = enq_pair.first;
        end
    end

    // ######################################################################
    // Shift queue
    // ######################################################################
    always_ff @(posedge clk) begin
        for (int i = 0; i < fbuf_depth; i++) begin
            if (i + n_deq < cnt) begin
                q[i] <= q[i + n_deq];                 // Move toward head.
            end else if (i == base && n_enq != '0) begin
                q[i] <= w0;
            end else if (i == base + 1 && n_enq == fbuf_cnt_w'(2)) begin
                q[i] <= w1;
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cnt <= '0;
        end else if (flush) begin
            cnt <= '0;                                // Empty at once.
        end else begin
            cnt <= base + n_enq;
        end
    end

    // ######################################################################
    // Decode slots
    // ######################################################################
    always_comb begin
        slot0.valid = (cnt != '0);
        slot0.pc    = q[0].pc;
        slot0.insn  = q[0].insn;
        slot1.valid = (cnt > fbuf_cnt_w'(1));
        slot1.pc    = q[1].pc;
        slot1.insn  = q[1].insn;
    end

    assign fill = cnt;

endmodule

`default_nettype wire

// ==== design/fetch_subsys_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_subsys_top import fetch_pkg::*; (
    input  wire logic                   clk,
    input  wire logic                   rstn,
    input  wire logic                   axil_awvalid,
    output logic                        axil_awready,
    input  wire logic [imem_addr_w-1:0] axil_awaddr,
    input  wire logic                   axil_wvalid,
    output logic                        axil_wready,
    input  wire logic [31:0]            axil_wdata,
    input  wire logic [3:0]             axil_wstrb,
    output logic                        axil_bvalid,
    input  wire logic                   axil_bready,
    output logic [1:0]                  axil_bresp,
    input  wire logic                   axil_arvalid,
    output logic                        axil_arready,
    input  wire logic [imem_addr_w-1:0] axil_araddr,
    output logic                        axil_rvalid,
    input  wire logic                   axil_rready,
    output logic [31:0]                 axil_rdata,
    output logic [1:0]                  axil_rresp,
    input  wire logic                   redirect_valid,
    input  wire logic [imem_addr_w-1:0] redirect_pc,
    output slot_t                       slot0,
    output slot_t                       slot1,
    input  wire logic                   take0,
    input  wire logic                   take1,
    output logic [fbuf_cnt_w-1:0]       fill
);

    mem_req_t               host_req;
    mem_req_t               fetch_req;
    mem_req_t               mem_req;
    logic                   host_gnt;
    logic                   fetch_gnt;
    logic [63:0]            mem_rdata;
    mem_rsp_t               rsp;                      // Shared by both peers.
    logic                   enq_valid;
    logic [imem_addr_w-1:0] enq_pc;
    fetch_pair_t            enq_pair;
    logic                   enq_skip_first;

    host_axil_port host_i (
        .clk, .rstn,
        .axil_awvalid, .axil_awready, .axil_awaddr,
        .axil_wvalid, .axil_wready, .axil_wdata, .axil_wstrb,
        .axil_bvalid, .axil_bready, .axil_bresp,
        .axil_arvalid, .axil_arready, .axil_araddr,
        .axil_rvalid, .axil_rready, .axil_rdata, .axil_rresp,
        .req(host_req), .gnt(host_gnt), .rsp
    );

    imem_arbiter arb_i (
        .clk, .rstn, .host_req, .fetch_req, .host_gnt, .fetch_gnt,
        .mem_req, .mem_rdata, .rsp
    );

    imem_ram ram_i (.clk, .req(mem_req), .rdata(mem_rdata));

    fetch_unit fetch_i (
        .clk, .rstn, .redirect_valid, .redirect_pc,
        .req(fetch_req), .gnt(fetch_gnt), .rsp, .fill,
        .enq_valid, .enq_pc, .enq_pair, .enq_skip_first
    );

    fetch_buffer fbuf_i (
        .clk, .rstn, .flush(redirect_valid),
        .enq_valid, .enq_pc, .enq_pair, .enq_skip_first,
        .take0, .take1, .slot0, .slot1, .fill
    );

endmodule

`default_nettype wire

// ==== verif/fetch_subsys_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_subsys_tb import fetch_pkg::*; ();

    localparam int n_writes      = 256;
    localparam int n_reads       = 64;
    localparam int n_busy_reads  = 48;                // Host reads during fetching.
    localparam int n_stream      = 160;
    localparam int n_odd         = 40;
    localparam int n_flushes     = 4;
    localparam int n_flush_words = 24;                // Upper bound per round.
    localparam int n_resume      = 60;
    localparam int cycle_limit   = 4 * (n_writes + n_reads + n_busy_reads + n_stream + n_odd
                                   + (n_flushes + 1) * n_flush_words + n_resume) + 2000;

    logic                   clk;
    logic                   rstn;
    logic                   axil_awvalid;
    logic                   axil_awready;
    logic [imem_addr_w-1:0] axil_awaddr;
    logic                   axil_wvalid;
    logic                   axil_wready;
    logic [31:0]            axil_wdata;
    logic [3:0]             axil_wstrb;
    logic                   axil_bvalid;
    logic                   axil_bready;
    logic [1:0]             axil_bresp;
    logic                   axil_arvalid;
    logic                   axil_arready;
    logic [imem_addr_w-1:0] axil_araddr;
    logic                   axil_rvalid;
    logic                   axil_rready;
    logic [31:0]            axil_rdata;
    logic [1:0]             axil_rresp;
    logic                   redirect_valid;
    logic [imem_addr_w-1:0] redirect_pc;
    slot_t                  slot0;
    slot_t                  slot1;
    logic                   take0;
    logic                   take1;
    logic [fbuf_cnt_w-1:0]  fill;

    insn_t                  model [256];              // Mirror of the memory.
    logic [imem_addr_w-1:0] exp_pc;                   // Next pc decode should see.
    int                     cycles = 0;

    fetch_subsys_top dut_i (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles.", cycle_limit);
            $display("Simulation FAILED");
            $fatal(1, "timeout");
        end
    end

    // ######################################################################
    // Compare tasks
    // ######################################################################
    task automatic stop_on_error();
        $display("Simulation FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_slot(input string name, input slot_t exp, input slot_t act);
        if (act.valid !== exp.valid || (exp.valid && (act.pc !== exp.pc ||
                                                       act.insn !== exp.insn))) begin
            $display("Fail %s: expected valid=%h pc=%h insn=%h, got valid=%h pc=%h insn=%h",
                     name, exp.valid, exp.pc, exp.insn, act.valid, act.pc, act.insn);
            stop_on_error();
        end
    endtask

    task automatic check_rdata(input insn_t exp, input insn_t act);
        if (act !== exp) begin
            $display("Fail axil_rdata: expected %h, got %h", exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_fill(input logic [fbuf_cnt_w-1:0] exp,
                              input logic [fbuf_cnt_w-1:0] act);
        if (act !== exp) begin
            $display("Fail fill: expected %h, got %h", exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_resp(input string name, input logic [1:0] exp, input logic [1:0] act);
        if (act !== exp) begin
            $display("Fail %s: expected %h, got %h", name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Fail %s: expected %h, got %h", name, exp, act);
            stop_on_error();
        end
    endtask

    // ######################################################################
    // Host side
    // ######################################################################
    task automatic host_response(input logic is_read, input insn_t exp_data);
        logic  vld;
        string vname;
        vname = is_read ? "axil_rvalid" : "axil_bvalid";
        vld   = 1'b0;
        while (!vld) begin
            @(negedge clk);
            vld = is_read ? axil_rvalid : axil_bvalid;
        end
        repeat ($urandom_range(3)) begin              // Ready held back.
            @(negedge clk);
            check_bit(vname, 1'b1, is_read ? axil_rvalid : axil_bvalid);
        end
        if (is_read) begin
            check_rdata(exp_data, axil_rdata);
            check_resp("axil_rresp", 2'b00, axil_rresp);
            axil_rready = 1'b1;
        end else begin
            check_resp("axil_bresp", 2'b00, axil_bresp);
            axil_bready = 1'b1;
        end
        @(negedge clk);
        axil_rready = 1'b0;
        axil_bready = 1'b0;
        check_bit(vname, 1'b0, is_read ? axil_rvalid : axil_bvalid);
    endtask

    task automatic host_write(input logic [imem_addr_w-1:0] addr, input insn_t data);
        logic hs;
        @(negedge clk);
        axil_awaddr  = addr;
        axil_wdata   = data;
        axil_wstrb   = 4'hf;
        axil_awvalid = 1'b1;
        axil_wvalid  = 1'b1;
        hs = 1'b0;
        while (!hs) begin
            #1;                                       // Ready depends on the valids.
            hs = axil_awready && axil_wready;
            @(negedge clk);
        end
        axil_awvalid = 1'b0;
        axil_wvalid  = 1'b0;
        host_response(1'b0, '0);
    endtask

    task automatic host_read(input logic [imem_addr_w-1:0] addr);
        logic hs;
        @(negedge clk);
        axil_araddr  = addr;
        axil_arvalid = 1'b1;
        hs = 1'b0;
        while (!hs) begin
            #1;
            hs = axil_arready;
            @(negedge clk);
        end
        axil_arvalid = 1'b0;
        host_response(1'b1, model[addr[imem_addr_w-1:2]]);
    endtask

    // ######################################################################
    // Decode side
    // ######################################################################
    function automatic slot_t expected_slot(input logic [imem_addr_w-1:0] pc);
        slot_t s;
        s.valid = 1'b1;
        s.pc    = pc;
        s.insn  = model[pc[imem_addr_w-1:2]];
        return s;
    endfunction

    task automatic take_word(input string name, input slot_t act);
        check_slot(name, expected_slot(exp_pc), act);
        exp_pc = exp_pc + imem_addr_w'(4);
    endtask

    task automatic consume(input int n_words);
        int got;
        int n;
        got = 0;
        while (got < n_words) begin
            @(negedge clk);
            n     = $urandom_range(2);
            take0 = (n > 0);
            take1 = (n == 2);
            if (take0 && slot0.valid) begin
                take_word("slot0", slot0);
                got++;
                if (take1 && slot1.valid) begin
                    take_word("slot1", slot1);
                    got++;
                end
            end
        end
        @(negedge clk);
        take0 = 1'b0;
        take1 = 1'b0;
    endtask

    task automatic redirect_to(input logic [imem_addr_w-1:0] pc);
        @(negedge clk);
        take0          = 1'b0;
        take1          = 1'b0;
        redirect_valid = 1'b1;
        redirect_pc    = pc;
        @(negedge clk);
        redirect_valid = 1'b0;
        exp_pc         = pc;
        check_slot("slot0", '0, slot0);               // Flushed at the edge.
        check_slot("slot1", '0, slot1);
        check_fill('0, fill);
    endtask

    // ######################################################################
    // Main sequence
    // ######################################################################
    initial begin
        void'($urandom(32'h66e7_d93f));
        clk            = 1'b0;
        rstn           = 1'b0;
        axil_awvalid   = 1'b0;
        axil_awaddr    = '0;
        axil_wvalid    = 1'b0;
        axil_wdata     = '0;
        axil_wstrb     = '0;
        axil_bready    = 1'b0;
        axil_arvalid   = 1'b0;
        axil_araddr    = '0;
        axil_rready    = 1'b0;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        take0          = 1'b0;
        take1          = 1'b0;
        exp_pc         = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);
        check_bit("axil_awready", 1'b1, axil_awready);
        check_bit("axil_wready", 1'b1, axil_wready);
        check_bit("axil_arready", 1'b1, axil_arready);
        check_bit("axil_bvalid", 1'b0, axil_bvalid);
        check_bit("axil_rvalid", 1'b0, axil_rvalid);
        check_slot("slot0", '0, slot0);
        check_slot("slot1", '0, slot1);
        check_fill('0, fill);

        for (int i = 0; i < n_writes; i++) begin
            model[i] = $urandom();
            host_write(imem_addr_w'(i * 4), model[i]);
        end
        for (int i = 0; i < n_reads; i++) begin
            host_read(imem_addr_w'($urandom_range(255) * 4));
        end
        check_fill('0, fill);                         // Idle until the first redirect.

        fork
            begin
                for (int i = 0; i < n_busy_reads; i++) begin
                    host_read(imem_addr_w'($urandom_range(255) * 4));
                end
            end
            begin
                redirect_to('0);
                consume(n_stream);
                redirect_to(imem_addr_w'($urandom_range(127) * 8 + 4));
                while (!slot0.valid) @(negedge clk);
                check_slot("slot0", expected_slot(exp_pc), slot0);
                consume(n_odd);
                for (int r = 0; r < n_flushes; r++) begin
                    consume($urandom_range(n_flush_words - 4, 4));
                    while (fill < fbuf_cnt_w'(2)) @(negedge clk);
                    repeat ($urandom_range(5)) @(negedge clk);
                    redirect_to(imem_addr_w'($urandom_range(255) * 4));
                end
                consume(n_flush_words - 4);
                repeat (40) begin                     // Decode stalls.
                    @(negedge clk);
                    if (fill > fbuf_depth) begin
                        $display("Fail fill: limit %h, got %h", fbuf_depth, fill);
                        stop_on_error();
                    end
                end
                // Full, or one word short when the head sits in the upper half of a line.
                check_fill(exp_pc[2] ? fbuf_cnt_w'(fbuf_depth - 1) : fbuf_cnt_w'(fbuf_depth),
                           fill);
                consume(n_resume);
            end
        join

        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== fetch_subsys.f ====
design/fetch_pkg.sv
design/imem_ram.sv
design/imem_arbiter.sv
design/host_axil_port.sv
design/fetch_unit.sv
design/fetch_buffer.sv
design/fetch_subsys_top.sv
verif/fetch_subsys_tb.sv

// ==== Makefile ====
# Verilator build and run for the fetch subsystem testbench.

SIM = obj_dir/Vfetch_subsys_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing -Wno-fatal --top-module fetch_subsys_tb \
		-f fetch_subsys.f -Mdir obj_dir

run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Simulation PASSED$$"

clean:
	rm -rf obj_dir
